/* files.f */
verilog/cache_pkg.sv
verilog/cache_ctrl.sv
verilog/cache_req_reg.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/blocking_cache.sv
sim/cache_mem_model.sv
sim/tb_blocking_cache.sv

/* Bender.yml */
package:
  name: blocking_cache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_req_reg.sv
  - verilog/cache_tag_array.sv
  - verilog/cache_data_array.sv
  - verilog/blocking_cache.sv
  - target: simulation
    files:
      - sim/cache_mem_model.sv
      - sim/tb_blocking_cache.sv

/* sim/tb_blocking_cache.sv */
//--------------------------------------------------------------------------
// Directed tests of the cache against a word-level memory reference.
// Test addresses stay below MEM_LINES lines of the memory model.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_blocking_cache
  import cache_pkg::*;
();

  localparam int NUM_SETS   = 8;
  localparam int MEM_LINES  = 256;
  localparam int MEM_WORDS  = MEM_LINES * WORDS_PER_LINE;
  localparam int SEED       = 32'hed7b;
  localparam int MAX_DELAY  = 4;
  localparam int N_RAND     = 40;
  localparam int N_DIRECTED = 16;
  // Write miss with a stalled response is the longest request
  localparam int REQ_CYCLES     = 16 + 2 * (MAX_DELAY + 4);
  localparam int TIMEOUT_CYCLES = 8 + (N_DIRECTED + N_RAND) * REQ_CYCLES;

  logic              clk;
  logic              rst;
  logic              cachereq_val;
  logic              cachereq_rdy;
  mem_op_e           cachereq_type;
  logic [ADDR_W-1:0] cachereq_addr;
  logic [DATA_W-1:0] cachereq_data;
  logic [OPQ_W-1:0]  cachereq_opaque;
  logic              cachereq_domain;
  logic              cacheresp_val;
  logic              cacheresp_rdy;
  mem_op_e           cacheresp_type;
  logic [DATA_W-1:0] cacheresp_data;
  logic [OPQ_W-1:0]  cacheresp_opaque;
  logic              cacheresp_domain;
  logic              memreq_val;
  logic              memreq_rdy;
  mem_op_e           memreq_type;
  logic [ADDR_W-1:0] memreq_addr;
  logic [LINE_W-1:0] memreq_data;
  logic              memreq_domain;
  logic              memresp_val;
  logic              memresp_rdy;
  mem_op_e           memresp_type;
  logic [LINE_W-1:0] memresp_data;

  logic [DATA_W-1:0] ref_mem [MEM_WORDS];
  integer            seed;
  int                cycles;
  int                rd_cnt;
  int                wr_cnt;
  logic              last_memreq_dom;
  int                word_errs;
  int                op_errs;
  int                count_errs;
  int                line_errs;
  int                other_errs;

  blocking_cache #(
    .p_num_sets (NUM_SETS)
  ) u_dut (
    .clk              (clk),
    .rst              (rst),
    .cachereq_val     (cachereq_val),
    .cachereq_rdy     (cachereq_rdy),
    .cachereq_type    (cachereq_type),
    .cachereq_addr    (cachereq_addr),
    .cachereq_data    (cachereq_data),
    .cachereq_opaque  (cachereq_opaque),
    .cachereq_domain  (cachereq_domain),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_rdy    (cacheresp_rdy),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_data   (cacheresp_data),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_domain (cacheresp_domain),
    .memreq_val       (memreq_val),
    .memreq_rdy       (memreq_rdy),
    .memreq_type      (memreq_type),
    .memreq_addr      (memreq_addr),
    .memreq_data      (memreq_data),
    .memreq_domain    (memreq_domain),
    .memresp_val      (memresp_val),
    .memresp_rdy      (memresp_rdy),
    .memresp_type     (memresp_type),
    .memresp_data     (memresp_data)
  );

  cache_mem_model #(
    .p_lines     (MEM_LINES),
    .p_seed      (SEED),
    .p_max_delay (MAX_DELAY)
  ) u_mem (
    .clk          (clk),
    .rst          (rst),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq_type  (memreq_type),
    .memreq_addr  (memreq_addr),
    .memreq_data  (memreq_data),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_type (memresp_type),
    .memresp_data (memresp_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Monitors
  //--------------------------------------------------------------------------

  // Count memory request transfers while val and rdy are stable
  always @(negedge clk) begin
    if (!rst && memreq_val && memreq_rdy) begin
      if (memreq_type == OP_READ) begin
        rd_cnt = rd_cnt + 1;
      end else begin
        wr_cnt = wr_cnt + 1;
      end
      last_memreq_dom = memreq_domain;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Odd multiplier keeps the preload word of every address distinct
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return (a * 32'h9e37_79b1) ^ 32'h1357_2468;
  endfunction

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------

  task automatic check_word(input string name, input logic chk_data,
                            input logic [DATA_W-1:0] exp_data,
                            input logic [DATA_W-1:0] act_data,
                            input logic [OPQ_W-1:0] exp_opq,
                            input logic [OPQ_W-1:0] act_opq,
                            input logic exp_dom, input logic act_dom);
    if (chk_data && act_data !== exp_data) begin
      word_errs++;
      $display("ERROR %s data: expected %h, actual %h", name, exp_data, act_data);
    end
    if (act_opq !== exp_opq) begin
      word_errs++;
      $display("ERROR %s opaque: expected %h, actual %h", name, exp_opq, act_opq);
    end
    if (act_dom !== exp_dom) begin
      word_errs++;
      $display("ERROR %s domain: expected %0d, actual %0d", name, exp_dom, act_dom);
    end
  endtask

  task automatic check_op(input string name, input mem_op_e exp, input mem_op_e act);
    if (act !== exp) begin
      op_errs++;
      $display("ERROR %s type: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      count_errs++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_line(input string name, input logic [LINE_W-1:0] exp,
                            input logic [LINE_W-1:0] act);
    if (act !== exp) begin
      line_errs++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //--------------------------------------------------------------------------
  // One request and its response, optionally with a stalled response
  //--------------------------------------------------------------------------

  task automatic access(input string name, input mem_op_e op,
                        input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                        input logic [OPQ_W-1:0] opq, input logic dom, input int stall);
    logic [DATA_W-1:0] exp_data;
    logic [DATA_W-1:0] act_data;
    logic [OPQ_W-1:0]  act_opq;
    logic              act_dom;
    mem_op_e           act_type;
    int                i;
    exp_data = ref_mem[addr[ADDR_W-1:2]];
    @(negedge clk);
    cachereq_val    = 1'b1;
    cachereq_type   = op;
    cachereq_addr   = addr;
    cachereq_data   = wdata;
    cachereq_opaque = opq;
    cachereq_domain = dom;
    cacheresp_rdy   = (stall == 0);
    while (!cachereq_rdy) @(negedge clk);
    @(negedge clk);
    cachereq_val = 1'b0;
    while (!cacheresp_val) @(negedge clk);
    act_data = cacheresp_data;
    act_opq  = cacheresp_opaque;
    act_dom  = cacheresp_domain;
    act_type = cacheresp_type;
    // Response must hold while the consumer stalls
    for (i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!cacheresp_val || cacheresp_data !== act_data || cacheresp_opaque !== act_opq ||
          cacheresp_domain !== act_dom || cacheresp_type !== act_type) begin
        other_errs++;
        $display("%s: response dropped or changed while cacheresp_rdy was low", name);
      end
      if (cachereq_rdy !== 1'b0) begin
        other_errs++;
        $display("%s: cachereq_rdy was high while a response was pending", name);
      end
    end
    cacheresp_rdy = 1'b1;
    @(negedge clk);
    check_op(name, op, act_type);
    if (op == OP_READ) begin
      check_word(name, 1'b1, exp_data, act_data, opq, act_opq, dom, act_dom);
    end else begin
      check_word(name, 1'b0, '0, act_data, opq, act_opq, dom, act_dom);
      ref_mem[addr[ADDR_W-1:2]] = wdata;
    end
  endtask

  //--------------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------------

  task automatic test_miss_then_hit();
    int rd0;
    rd0 = rd_cnt;
    access("miss_then_hit miss", OP_READ, 32'h0000_0044, '0, 8'h11, 1'b0, 0);
    check_count("miss_then_hit miss memreq", 1, rd_cnt - rd0);
    rd0 = rd_cnt;
    access("miss_then_hit hit", OP_READ, 32'h0000_0044, '0, 8'h12, 1'b0, 0);
    check_count("miss_then_hit hit memreq", 0, rd_cnt - rd0);
  endtask

  task automatic test_write_then_read();
    logic [LINE_W-1:0] exp_line;
    int                wr0;
    int                w;
    wr0 = wr_cnt;
    access("write_then_read write", OP_WRITE, 32'h0000_0088, 32'hdead_beef, 8'h21, 1'b0, 0);
    check_count("write_then_read line writes", 1, wr_cnt - wr0);
    access("write_then_read read", OP_READ, 32'h0000_0088, '0, 8'h22, 1'b0, 0);
    for (w = 0; w < WORDS_PER_LINE; w++) begin
      exp_line[w*DATA_W +: DATA_W] = ref_mem[(32'h80 >> 2) + w];
    end
    check_line("write_then_read memory line", exp_line, u_mem.mem[32'h80 >> LINE_OFS_W]);
  endtask

  // A, B and C all map to set 3
  task automatic test_lru();
    int rd0;
    access("lru A", OP_READ, 32'h0000_0034, '0, 8'h31, 1'b0, 0);
    access("lru B", OP_READ, 32'h0000_0138, '0, 8'h32, 1'b0, 0);
    access("lru A again", OP_READ, 32'h0000_0034, '0, 8'h33, 1'b0, 0);
    access("lru C", OP_READ, 32'h0000_023c, '0, 8'h34, 1'b0, 0);
    rd0 = rd_cnt;
    access("lru A kept", OP_READ, 32'h0000_0030, '0, 8'h35, 1'b0, 0);
    check_count("lru A kept memreq", 0, rd_cnt - rd0);
    rd0 = rd_cnt;
    access("lru B evicted", OP_READ, 32'h0000_0134, '0, 8'h36, 1'b0, 0);
    check_count("lru B evicted memreq", 1, rd_cnt - rd0);
  endtask

  task automatic test_domain();
    int rd0;
    access("domain fill d0", OP_READ, 32'h0000_0058, '0, 8'h41, 1'b0, 0);
    rd0 = rd_cnt;
    access("domain read d1", OP_READ, 32'h0000_0058, '0, 8'h42, 1'b1, 0);
    check_count("domain read d1 memreq", 1, rd_cnt - rd0);
    check_count("domain read d1 memreq_domain", 1, int'(last_memreq_dom));
    rd0 = rd_cnt;
    access("domain read d0", OP_READ, 32'h0000_0058, '0, 8'h43, 1'b0, 0);
    check_count("domain read d0 memreq", 0, rd_cnt - rd0);
  endtask

  task automatic test_backpressure();
    access("backpressure read", OP_READ, 32'h0000_0064, '0, 8'ha7, 1'b1, 6);
    access("backpressure write", OP_WRITE, 32'h0000_0068, 32'h0bad_f00d, 8'h5c, 1'b1, 3);
  endtask

  // Sets 0..3 with two tags per domain
  // A line held by both domains would go stale on a write through one of them
  task automatic test_random();
    logic [31:0]       r;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    int                n;
    for (n = 0; n < N_RAND; n++) begin
      r           = $random(seed);
      wdata       = $random(seed);
      addr        = '0;
      addr[8]     = r[7];
      addr[7]     = r[0];
      addr[5:4]   = r[3:2];
      addr[3:2]   = r[5:4];
      access("random", mem_op_e'(r[6]), addr, wdata, r[15:8], r[7], 0);
    end
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin
    logic [LINE_W-1:0] line;
    int                i;
    int                w;
    seed            = SEED;
    cycles          = 0;
    rd_cnt          = 0;
    wr_cnt          = 0;
    last_memreq_dom = 1'b0;
    word_errs       = 0;
    op_errs         = 0;
    count_errs      = 0;
    line_errs       = 0;
    other_errs      = 0;
    rst             = 1'b1;
    cachereq_val    = 1'b0;
    cachereq_type   = OP_READ;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cachereq_opaque = '0;
    cachereq_domain = 1'b0;
    cacheresp_rdy   = 1'b1;

    for (i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i * 4);
    end
    for (i = 0; i < MEM_LINES; i++) begin
      for (w = 0; w < WORDS_PER_LINE; w++) begin
        line[w*DATA_W +: DATA_W] = ref_mem[i*WORDS_PER_LINE + w];
      end
      u_mem.mem[i] = line;
    end

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_miss_then_hit();
    test_write_then_read();
    test_lru();
    test_domain();
    test_backpressure();
    test_random();

    repeat (4) @(negedge clk);
    $display("Errors: word %0d, type %0d, count %0d, line %0d, other %0d",
             word_errs, op_errs, count_errs, line_errs, other_errs);
    if (word_errs + op_errs + count_errs + line_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim/cache_mem_model.sv */
//--------------------------------------------------------------------------
// Line memory, one request at a time. Contents are loaded from outside.
// Addresses wrap at p_lines lines. Writes are acknowledged with no data.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cache_mem_model
  import cache_pkg::*;
#(
  parameter int p_lines     = 256,
  parameter int p_seed      = 1,
  parameter int p_max_delay = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              memreq_val,
  output logic              memreq_rdy,
  input  mem_op_e           memreq_type,
  input  logic [ADDR_W-1:0] memreq_addr,
  input  logic [LINE_W-1:0] memreq_data,
  output logic              memresp_val,
  input  logic              memresp_rdy,
  output mem_op_e           memresp_type,
  output logic [LINE_W-1:0] memresp_data
);

  localparam int lidx_w = $clog2(p_lines);

  logic [LINE_W-1:0] mem [p_lines];
  logic              busy_q;
  logic              resp_q;
  int                delay_q;
  mem_op_e           type_q;
  logic [LINE_W-1:0] data_q;
  integer            seed;

  initial seed = p_seed;

  assign memreq_rdy   = !busy_q;
  assign memresp_val  = resp_q;
  assign memresp_type = type_q;
  assign memresp_data = data_q;

  // Accept, wait a random number of cycles, then answer
  always @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      resp_q  <= 1'b0;
      delay_q <= 0;
      type_q  <= OP_READ;
    end else if (!busy_q) begin
      if (memreq_val) begin
        busy_q  <= 1'b1;
        type_q  <= memreq_type;
        delay_q <= {$random(seed)} % (p_max_delay + 1);
        if (memreq_type == OP_WRITE) begin
          mem[memreq_addr[LINE_OFS_W +: lidx_w]] <= memreq_data;
          data_q <= '0;
        end else begin
          data_q <= mem[memreq_addr[LINE_OFS_W +: lidx_w]];
        end
      end
    end else if (!resp_q) begin
      if (delay_q == 0) begin
        resp_q <= 1'b1;
      end else begin
        delay_q <= delay_q - 1;
      end
    end else if (memresp_rdy) begin
      resp_q <= 1'b0;
      busy_q <= 1'b0;
    end
  end

endmodule

/* verilog/blocking_cache.sv */
//--------------------------------------------------------------------------
// Write-through, write-allocate, two-way cache with per-line domain bit.
// Blocking: one request at a time. p_num_sets is a power of two, at least 2.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module blocking_cache
  import cache_pkg::*;
#(
  parameter int p_num_sets = 8
) (
  input  logic              clk,
  input  logic              rst,

  // Cache request
  input  logic              cachereq_val,
  output logic              cachereq_rdy,
  input  mem_op_e           cachereq_type,
  input  logic [ADDR_W-1:0] cachereq_addr,
  input  logic [DATA_W-1:0] cachereq_data,
  input  logic [OPQ_W-1:0]  cachereq_opaque,
  input  logic              cachereq_domain,

  // Cache response
  output logic              cacheresp_val,
  input  logic              cacheresp_rdy,
  output mem_op_e           cacheresp_type,
  output logic [DATA_W-1:0] cacheresp_data,
  output logic [OPQ_W-1:0]  cacheresp_opaque,
  output logic              cacheresp_domain,

  // Memory request
  output logic              memreq_val,
  input  logic              memreq_rdy,
  output mem_op_e           memreq_type,
  output logic [ADDR_W-1:0] memreq_addr,
  output logic [LINE_W-1:0] memreq_data,
  output logic              memreq_domain,

  // Memory response
  input  logic              memresp_val,
  output logic              memresp_rdy,
  input  mem_op_e           memresp_type,
  input  logic [LINE_W-1:0] memresp_data
);

  localparam int idx_w = $clog2(p_num_sets);
  localparam int tag_w = ADDR_W - idx_w - LINE_OFS_W;

  //------------------------------------------------------------------------
  // Control to datapath
  //------------------------------------------------------------------------

  logic req_en;
  logic refill_en;
  logic tag_wen;
  logic lru_update;
  logic data_wen;
  logic data_src_mem;
  logic way_fill;

  //------------------------------------------------------------------------
  // Datapath status and request fields
  //------------------------------------------------------------------------

  mem_op_e                 req_type;
  logic [tag_w-1:0]        req_tag;
  logic [idx_w-1:0]        req_index;
  logic [WORD_SEL_W-1:0]   req_offset;
  logic                    req_domain;
  logic [LINE_W-1:0]       merge_line;
  logic [LINE_W-1:0]       hit_line;
  logic                    hit;
  logic                    hit_way;
  logic                    victim_way;

  cache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .cachereq_val   (cachereq_val),
    .cachereq_rdy   (cachereq_rdy),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_rdy  (cacheresp_rdy),
    .cacheresp_type (cacheresp_type),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memreq_type    (memreq_type),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .memresp_type   (memresp_type),
    .req_type       (req_type),
    .hit            (hit),
    .hit_way        (hit_way),
    .victim_way     (victim_way),
    .req_en         (req_en),
    .refill_en      (refill_en),
    .tag_wen        (tag_wen),
    .lru_update     (lru_update),
    .data_wen       (data_wen),
    .data_src_mem   (data_src_mem),
    .way_fill       (way_fill)
  );

  cache_req_reg #(
    .p_num_sets (p_num_sets)
  ) u_req_reg (
    .clk              (clk),
    .rst              (rst),
    .req_en           (req_en),
    .refill_en        (refill_en),
    .cachereq_type    (cachereq_type),
    .cachereq_addr    (cachereq_addr),
    .cachereq_data    (cachereq_data),
    .cachereq_opaque  (cachereq_opaque),
    .cachereq_domain  (cachereq_domain),
    .memresp_data     (memresp_data),
    .hit_line         (hit_line),
    .req_type         (req_type),
    .req_tag          (req_tag),
    .req_index        (req_index),
    .req_offset       (req_offset),
    .req_domain       (req_domain),
    .merge_line       (merge_line),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_domain (cacheresp_domain),
    .memreq_addr      (memreq_addr),
    .memreq_domain    (memreq_domain)
  );

  cache_tag_array #(
    .p_num_sets (p_num_sets)
  ) u_tag_array (
    .clk        (clk),
    .rst        (rst),
    .req_index  (req_index),
    .req_tag    (req_tag),
    .req_domain (req_domain),
    .tag_wen    (tag_wen),
    .lru_update (lru_update),
    .way_fill   (way_fill),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  // Refill line comes straight from the memory response
  cache_data_array #(
    .p_num_sets (p_num_sets)
  ) u_data_array (
    .clk            (clk),
    .req_index      (req_index),
    .req_offset     (req_offset),
    .way_fill       (way_fill),
    .hit_way        (hit_way),
    .data_wen       (data_wen),
    .data_src_mem   (data_src_mem),
    .refill_line    (memresp_data),
    .merge_line     (merge_line),
    .hit_line       (hit_line),
    .cacheresp_data (cacheresp_data),
    .memreq_data    (memreq_data)
  );

endmodule

/* verilog/cache_data_array.sv */
//--------------------------------------------------------------------------
// Two lines per set, asynchronous read of the way selected by hit_way.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cache_data_array
  import cache_pkg::*;
#(
  parameter int p_num_sets = 8
) (
  input  logic                          clk,
  input  logic [$clog2(p_num_sets)-1:0] req_index,
  input  logic [WORD_SEL_W-1:0]         req_offset,
  input  logic                          way_fill,
  input  logic                          hit_way,
  input  logic                          data_wen,
  input  logic                          data_src_mem,
  input  logic [LINE_W-1:0]             refill_line,
  input  logic [LINE_W-1:0]             merge_line,
  output logic [LINE_W-1:0]             hit_line,
  output logic [DATA_W-1:0]             cacheresp_data,
  output logic [LINE_W-1:0]             memreq_data
);

  logic [LINE_W-1:0] line_mem [p_num_sets][2];
  logic [LINE_W-1:0] wr_line;

  // Refill data straight from memory, or the merged write line
  assign wr_line = data_src_mem ? refill_line : merge_line;

  always_ff @(posedge clk) begin
    if (data_wen) begin
      line_mem[req_index][way_fill] <= wr_line;
    end
  end

  //------------------------------------------------------------------------
  // Read side
  //------------------------------------------------------------------------

  assign hit_line = line_mem[req_index][hit_way];

  // Word for the response
  assign cacheresp_data = hit_line[req_offset*DATA_W +: DATA_W];

  // Stored line goes out as the line-write payload
  assign memreq_data = hit_line;

endmodule

/* verilog/cache_tag_array.sv */
//--------------------------------------------------------------------------
// Two ways per set. A hit needs valid, tag and domain to match.
// One LRU bit per set names the way to replace next.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cache_tag_array
  import cache_pkg::*;
#(
  parameter int p_num_sets = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [$clog2(p_num_sets)-1:0]        req_index,
  input  logic [ADDR_W-$clog2(p_num_sets)-LINE_OFS_W-1:0] req_tag,
  input  logic                                 req_domain,
  input  logic                                 tag_wen,
  input  logic                                 lru_update,
  input  logic                                 way_fill,
  output logic                                 hit,
  output logic                                 hit_way,
  output logic                                 victim_way
);

  localparam int idx_w = $clog2(p_num_sets);
  localparam int tag_w = ADDR_W - idx_w - LINE_OFS_W;

  logic [tag_w-1:0] tag_mem [p_num_sets][2];
  logic             dom_mem [p_num_sets][2];
  logic [1:0]       valid_q [p_num_sets];
  logic [p_num_sets-1:0] lru_q;
  logic [1:0]       way_match;

  // Tag and domain storage
  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tag_mem[req_index][way_fill] <= req_tag;
      dom_mem[req_index][way_fill] <= req_domain;
    end
  end

  // Valid and LRU state
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < p_num_sets; s++) begin
        valid_q[s] <= 2'b00;
      end
      lru_q <= '0;
    end else begin
      if (tag_wen) begin
        valid_q[req_index][way_fill] <= 1'b1;
      end
      // Point at the way not just used
      if (lru_update) begin
        lru_q[req_index] <= ~way_fill;
      end
    end
  end

  // Per-way compare
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_match[w] = valid_q[req_index][w] &&
                     (tag_mem[req_index][w] == req_tag) &&
                     (dom_mem[req_index][w] == req_domain);
    end
  end

  assign hit     = |way_match;
  assign hit_way = way_match[1];

  // Fill an empty way before evicting
  assign victim_way = !valid_q[req_index][0] ? 1'b0 :
                      !valid_q[req_index][1] ? 1'b1 :
                      lru_q[req_index];

endmodule

/* verilog/cache_req_reg.sv */
//--------------------------------------------------------------------------
// p_num_sets must be a power of two, at least 2.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cache_req_reg
  import cache_pkg::*;
#(
  parameter int p_num_sets = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 req_en,
  input  logic                                 refill_en,
  input  mem_op_e                              cachereq_type,
  input  logic [ADDR_W-1:0]                    cachereq_addr,
  input  logic [DATA_W-1:0]                    cachereq_data,
  input  logic [OPQ_W-1:0]                     cachereq_opaque,
  input  logic                                 cachereq_domain,
  input  logic [LINE_W-1:0]                    memresp_data,
  input  logic [LINE_W-1:0]                    hit_line,
  output mem_op_e                              req_type,
  output logic [ADDR_W-$clog2(p_num_sets)-LINE_OFS_W-1:0] req_tag,
  output logic [$clog2(p_num_sets)-1:0]        req_index,
  output logic [WORD_SEL_W-1:0]                req_offset,
  output logic                                 req_domain,
  output logic [LINE_W-1:0]                    merge_line,
  output logic [OPQ_W-1:0]                     cacheresp_opaque,
  output logic                                 cacheresp_domain,
  output logic [ADDR_W-1:0]                    memreq_addr,
  output logic                                 memreq_domain
);

  localparam int idx_w = $clog2(p_num_sets);

  mem_op_e           type_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;
  logic [OPQ_W-1:0]  opaque_q;
  logic              domain_q;
  logic [LINE_W-1:0] refill_q;
  logic              refilled_q;

  // Request payload
  always_ff @(posedge clk) begin
    if (req_en) begin
      type_q   <= cachereq_type;
      addr_q   <= cachereq_addr;
      data_q   <= cachereq_data;
      opaque_q <= cachereq_opaque;
      domain_q <= cachereq_domain;
    end
    if (refill_en) begin
      refill_q <= memresp_data;
    end
  end

  // Marks that the current request has a refilled line
  always_ff @(posedge clk) begin
    if (rst || req_en) begin
      refilled_q <= 1'b0;
    end else if (refill_en) begin
      refilled_q <= 1'b1;
    end
  end

  // Address split into tag, index, word and byte offset
  assign req_type   = type_q;
  assign req_tag    = addr_q[ADDR_W-1:LINE_OFS_W+idx_w];
  assign req_index  = addr_q[LINE_OFS_W +: idx_w];
  assign req_offset = addr_q[LINE_OFS_W-1 -: WORD_SEL_W];
  assign req_domain = domain_q;

  // Write word replaces one word of the current line
  always_comb begin
    merge_line = refilled_q ? refill_q : hit_line;
    merge_line[req_offset*DATA_W +: DATA_W] = data_q;
  end

  assign cacheresp_opaque = opaque_q;
  assign cacheresp_domain = domain_q;
  assign memreq_addr      = {addr_q[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
  assign memreq_domain    = domain_q;

endmodule

/* verilog/cache_ctrl.sv */
//--------------------------------------------------------------------------
// One request in flight. Writes always end with a full-line memory write.
// Memory responses of the wrong type are consumed and ignored.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  // External handshakes
  input  logic    cachereq_val,
  output logic    cachereq_rdy,
  output logic    cacheresp_val,
  input  logic    cacheresp_rdy,
  output mem_op_e cacheresp_type,
  output logic    memreq_val,
  input  logic    memreq_rdy,
  output mem_op_e memreq_type,
  input  logic    memresp_val,
  output logic    memresp_rdy,
  input  mem_op_e memresp_type,

  // Status from the datapath
  input  mem_op_e req_type,
  input  logic    hit,
  input  logic    hit_way,
  input  logic    victim_way,

  // Datapath enables
  output logic    req_en,
  output logic    refill_en,
  output logic    tag_wen,
  output logic    lru_update,
  output logic    data_wen,
  output logic    data_src_mem,
  output logic    way_fill
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Hit way on a hit, replacement candidate otherwise
  assign way_fill = hit ? hit_way : victim_way;

  assign cacheresp_type = req_type;

  always_comb begin
    state_d       = state_q;
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memreq_type   = OP_READ;
    memresp_rdy   = 1'b0;
    req_en        = 1'b0;
    refill_en     = 1'b0;
    tag_wen       = 1'b0;
    lru_update    = 1'b0;
    data_wen      = 1'b0;
    data_src_mem  = 1'b0;

    case (state_q)
      ST_IDLE: begin
        cachereq_rdy = 1'b1;
        if (cachereq_val) begin
          req_en  = 1'b1;
          state_d = ST_LOOKUP;
        end
      end

      ST_LOOKUP: begin
        if (hit) begin
          lru_update = 1'b1;
          if (req_type == OP_WRITE) begin
            // Merge the write word into the hit line
            data_wen = 1'b1;
            state_d  = ST_WRITE_REQ;
          end else begin
            state_d = ST_RESP;
          end
        end else begin
          state_d = ST_REFILL_REQ;
        end
      end

      ST_REFILL_REQ: begin
        memreq_val  = 1'b1;
        memreq_type = OP_READ;
        if (memreq_rdy) begin
          state_d = ST_REFILL_WAIT;
        end
      end

      ST_REFILL_WAIT: begin
        memresp_rdy = 1'b1;
        if (memresp_val && memresp_type == OP_READ) begin
          refill_en    = 1'b1;
          tag_wen      = 1'b1;
          data_wen     = 1'b1;
          data_src_mem = 1'b1;
          lru_update   = 1'b1;
          // A write miss looks up again, now hits and merges
          state_d      = (req_type == OP_WRITE) ? ST_LOOKUP : ST_RESP;
        end
      end

      ST_WRITE_REQ: begin
        memreq_val  = 1'b1;
        memreq_type = OP_WRITE;
        if (memreq_rdy) begin
          state_d = ST_WRITE_WAIT;
        end
      end

      ST_WRITE_WAIT: begin
        memresp_rdy = 1'b1;
        if (memresp_val && memresp_type == OP_WRITE) begin
          state_d = ST_RESP;
        end
      end

      ST_RESP: begin
        cacheresp_val = 1'b1;
        if (cacheresp_rdy) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

endmodule

/* verilog/cache_pkg.sv */
//--------------------------------------------------------------------------
// Lines are four 32-bit words. Sub-word writes and atomics are not supported.
// The request and response type fields share one 1-bit opcode encoding.
//--------------------------------------------------------------------------
package cache_pkg;

  // Datapath widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LINE_W = 128;
  localparam int OPQ_W  = 8;

  localparam int WORDS_PER_LINE = LINE_W / DATA_W;

  // Word select within a line, and byte offset bits below the index
  localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
  localparam int LINE_OFS_W = $clog2(LINE_W / 8);

  // Request, response and memory message type
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_WRITE_REQ,
    ST_WRITE_WAIT,
    ST_RESP
  } ctrl_state_e;

endpackage
